// File: src/avmm_pkg.sv
`default_nettype none

package avmm_pkg;

    // Word address and data widths shared by every block in the subsystem
    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // Default register slice depth for the request and response paths
    localparam int N_REG_STAGES = 1;
    // Waitrequest travels through its own shift register of this length
    localparam int N_WAITREQUEST_STAGES = N_REG_STAGES;

    // Command queue inside the memory slave
    localparam int MEM_FIFO_DEPTH = 8;
    localparam int MEM_PTR_WIDTH = $clog2(MEM_FIFO_DEPTH);
    // Slots still free when waitrequest rises
    // Covers the slice stages, the waitrequest delay and the register turnaround
    localparam int MEM_SLACK = N_REG_STAGES + N_WAITREQUEST_STAGES + 1;

    // Read-return order queue inside the arbiter
    localparam int RD_ORDER_DEPTH = 8;
    localparam int RD_ORDER_PTR_WIDTH = $clog2(RD_ORDER_DEPTH);

    // Which master port owns a grant or an outstanding read
    typedef enum logic
    {
        PORT_A,
        PORT_B
    } arb_owner_e;

    // Opcode held in each memory FIFO entry
    typedef enum logic [1:0]
    {
        CMD_NONE,
        CMD_READ,
        CMD_WRITE
    } mem_cmd_e;

endpackage

`default_nettype wire

// File: src/avmm_arbiter.sv
`default_nettype none

module avmm_arbiter import avmm_pkg::*;
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] a_address,
    input  logic                  a_read,
    input  logic                  a_write,
    input  logic [DATA_WIDTH-1:0] a_writedata,
    input  logic [BE_WIDTH-1:0]   a_byteenable,
    output logic                  a_waitrequest,
    output logic [DATA_WIDTH-1:0] a_readdata,
    output logic                  a_readdatavalid,
    input  logic [ADDR_WIDTH-1:0] b_address,
    input  logic                  b_read,
    input  logic                  b_write,
    input  logic [DATA_WIDTH-1:0] b_writedata,
    input  logic [BE_WIDTH-1:0]   b_byteenable,
    output logic                  b_waitrequest,
    output logic [DATA_WIDTH-1:0] b_readdata,
    output logic                  b_readdatavalid,
    output logic [ADDR_WIDTH-1:0] arb_address,
    output logic                  arb_read,
    output logic                  arb_write,
    output logic [DATA_WIDTH-1:0] arb_writedata,
    output logic [BE_WIDTH-1:0]   arb_byteenable,
    input  logic                  arb_waitrequest,
    input  logic [DATA_WIDTH-1:0] arb_readdata,
    input  logic                  arb_readdatavalid
);

    arb_owner_e                    last_owner;
    arb_owner_e                    grant;
    arb_owner_e                    ord_fifo [RD_ORDER_DEPTH];
    arb_owner_e                    ord_head;
    logic [RD_ORDER_PTR_WIDTH-1:0] ord_wr_ptr;
    logic [RD_ORDER_PTR_WIDTH-1:0] ord_rd_ptr;
    logic [RD_ORDER_PTR_WIDTH:0]   ord_count;
    logic                          ord_full;
    logic                          ord_push;
    logic                          ord_pop;
    logic                          a_elig;
    logic                          b_elig;

    assign ord_full = (ord_count == (RD_ORDER_PTR_WIDTH+1)'(RD_ORDER_DEPTH));

    // A read may only compete while its owner can still be recorded
    // Writes need no return slot and always compete
    assign a_elig = a_write || (a_read && !ord_full);
    assign b_elig = b_write || (b_read && !ord_full);

    // On a tie the port that did not win last time gets the bus
    always_comb
    begin
        if (a_elig && b_elig)
            grant = (last_owner == PORT_B) ? PORT_A : PORT_B;
        else if (b_elig)
            grant = PORT_B;
        else
            grant = PORT_A;
    end

    // The request path is purely combinational so both sides accept together
    always_comb
    begin
        if (grant == PORT_A)
        begin
            arb_address    = a_address;
            arb_read       = a_read && a_elig;
            arb_write      = a_write;
            arb_writedata  = a_writedata;
            arb_byteenable = a_byteenable;
        end
        else
        begin
            arb_address    = b_address;
            arb_read       = b_read && b_elig;
            arb_write      = b_write;
            arb_writedata  = b_writedata;
            arb_byteenable = b_byteenable;
        end
    end

    // A requesting port stalls when the other port won or its read has no return slot
    assign a_waitrequest = arb_waitrequest ||
                           ((a_read || a_write) && !(a_elig && grant == PORT_A));
    assign b_waitrequest = arb_waitrequest ||
                           ((b_read || b_write) && !(b_elig && grant == PORT_B));

    // Responses come back in issue order so the queue head names the owner
    assign ord_head = ord_fifo[ord_rd_ptr];
    assign ord_push = arb_read && !arb_waitrequest;
    assign ord_pop  = arb_readdatavalid;

    assign a_readdata      = arb_readdata;
    assign b_readdata      = arb_readdata;
    assign a_readdatavalid = arb_readdatavalid && (ord_head == PORT_A);
    assign b_readdatavalid = arb_readdatavalid && (ord_head == PORT_B);

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            // Port a wins the first tie after reset
            last_owner <= PORT_B;
            ord_wr_ptr <= '0;
            ord_rd_ptr <= '0;
            ord_count  <= '0;
        end
        else
        begin
            // Ownership only moves once the request is really taken
            if ((arb_read || arb_write) && !arb_waitrequest)
                last_owner <= grant;
            if (ord_push)
                ord_wr_ptr <= ord_wr_ptr + 1'b1;
            if (ord_pop)
                ord_rd_ptr <= ord_rd_ptr + 1'b1;
            if (ord_push && !ord_pop)
                ord_count <= ord_count + 1'b1;
            else if (ord_pop && !ord_push)
                ord_count <= ord_count - 1'b1;
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (ord_push)
            ord_fifo[ord_wr_ptr] <= grant;
    end

    // Every response downstream must match a read recorded here earlier
    a_rdv_has_owner: assert property (@(posedge mem_slave) disable iff (!rst_n)
        arb_readdatavalid |-> (ord_count != '0));

    // The merged request path carries one operation per cycle
    a_one_op: assert property (@(posedge mem_slave) disable iff (!rst_n)
        !(arb_read && arb_write));

endmodule

`default_nettype wire

// File: src/avmm_reg_slice.sv
`default_nettype none

module avmm_reg_slice import avmm_pkg::*;
#(
    parameter int N_STAGES    = N_REG_STAGES,
    parameter int N_WR_STAGES = N_WAITREQUEST_STAGES
)
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] up_address,
    input  logic                  up_read,
    input  logic                  up_write,
    input  logic [DATA_WIDTH-1:0] up_writedata,
    input  logic [BE_WIDTH-1:0]   up_byteenable,
    output logic                  up_waitrequest,
    output logic [DATA_WIDTH-1:0] up_readdata,
    output logic                  up_readdatavalid,
    output logic [ADDR_WIDTH-1:0] dn_address,
    output logic                  dn_read,
    output logic                  dn_write,
    output logic [DATA_WIDTH-1:0] dn_writedata,
    output logic [BE_WIDTH-1:0]   dn_byteenable,
    input  logic                  dn_waitrequest,
    input  logic [DATA_WIDTH-1:0] dn_readdata,
    input  logic                  dn_readdatavalid
);

    generate
        if (N_STAGES == 0)
        begin : g_wires
            assign dn_address       = up_address;
            assign dn_read          = up_read;
            assign dn_write         = up_write;
            assign dn_writedata     = up_writedata;
            assign dn_byteenable    = up_byteenable;
            assign up_waitrequest   = dn_waitrequest;
            assign up_readdata      = dn_readdata;
            assign up_readdatavalid = dn_readdatavalid;
        end
        else
        begin : g_regs
            // Stage 1 is nearest the upstream side and the last stage drives downstream
            logic [ADDR_WIDTH-1:0] req_address   [1:N_STAGES];
            logic [DATA_WIDTH-1:0] req_writedata [1:N_STAGES];
            logic [BE_WIDTH-1:0]   req_byteenable[1:N_STAGES];
            logic [N_STAGES:1]     req_read;
            logic [N_STAGES:1]     req_write;
            logic [DATA_WIDTH-1:0] rsp_readdata  [1:N_STAGES];
            logic [N_STAGES:1]     rsp_valid;
            // Downstream waitrequest enters at bit 1
            logic [N_WR_STAGES:1]  wr_pipe;

            // Upstream sees the delayed waitrequest as an almost-full flag
            assign up_waitrequest = wr_pipe[N_WR_STAGES];

            always_ff @(posedge mem_slave)
            begin
                // Payload moves every cycle and its valid bit decides whether it counts
                req_address[1]    <= up_address;
                req_writedata[1]  <= up_writedata;
                req_byteenable[1] <= up_byteenable;
                rsp_readdata[1]   <= dn_readdata;
                for (int k = 2; k <= N_STAGES; k++)
                begin
                    req_address[k]    <= req_address[k-1];
                    req_writedata[k]  <= req_writedata[k-1];
                    req_byteenable[k] <= req_byteenable[k-1];
                    rsp_readdata[k]   <= rsp_readdata[k-1];
                end

                if (!rst_n)
                begin
                    req_read  <= '0;
                    req_write <= '0;
                    rsp_valid <= '0;
                    // Upstream stays stalled until real waitrequest values shift through
                    wr_pipe   <= '1;
                end
                else
                begin
                    // Requests are taken blindly unless the delayed flag says stop
                    req_read  <= N_STAGES'({req_read, up_read && !up_waitrequest});
                    req_write <= N_STAGES'({req_write, up_write && !up_waitrequest});
                    rsp_valid <= N_STAGES'({rsp_valid, dn_readdatavalid});
                    wr_pipe   <= N_WR_STAGES'({wr_pipe, dn_waitrequest});
                end
            end

            assign dn_address       = req_address[N_STAGES];
            assign dn_read          = req_read[N_STAGES];
            assign dn_write         = req_write[N_STAGES];
            assign dn_writedata     = req_writedata[N_STAGES];
            assign dn_byteenable    = req_byteenable[N_STAGES];
            assign up_readdata      = rsp_readdata[N_STAGES];
            assign up_readdatavalid = rsp_valid[N_STAGES];
        end
    endgenerate

endmodule

`default_nettype wire

// File: src/avmm_mem.sv
`default_nettype none

module avmm_mem import avmm_pkg::*;
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  logic                  refresh,
    input  logic [ADDR_WIDTH-1:0] address,
    input  logic                  read,
    input  logic                  write,
    input  logic [DATA_WIDTH-1:0] writedata,
    input  logic [BE_WIDTH-1:0]   byteenable,
    output logic                  waitrequest,
    output logic [DATA_WIDTH-1:0] readdata,
    output logic                  readdatavalid
);

    logic [DATA_WIDTH-1:0]    mem_array [1 << ADDR_WIDTH];
    mem_cmd_e                 fifo_cmd  [MEM_FIFO_DEPTH];
    logic [ADDR_WIDTH-1:0]    fifo_addr [MEM_FIFO_DEPTH];
    logic [DATA_WIDTH-1:0]    fifo_data [MEM_FIFO_DEPTH];
    logic [BE_WIDTH-1:0]      fifo_be   [MEM_FIFO_DEPTH];
    logic [MEM_PTR_WIDTH-1:0] wr_ptr;
    logic [MEM_PTR_WIDTH-1:0] rd_ptr;
    logic [MEM_PTR_WIDTH:0]   count;
    logic [MEM_PTR_WIDTH:0]   free_slots;
    logic                     push;
    logic                     pop;
    mem_cmd_e                 head_cmd;
    logic [ADDR_WIDTH-1:0]    head_addr;

    // The slice already qualified these strobes so every one must be queued
    assign push = read || write;

    // Nothing is served while refresh holds the array
    assign head_cmd  = (count != '0 && !refresh) ? fifo_cmd[rd_ptr] : CMD_NONE;
    assign head_addr = fifo_addr[rd_ptr];
    assign pop       = (head_cmd != CMD_NONE);

    // Stall early enough that requests still in the slice find room
    assign free_slots  = (MEM_PTR_WIDTH+1)'(MEM_FIFO_DEPTH) - count;
    assign waitrequest = (free_slots <= (MEM_PTR_WIDTH+1)'(MEM_SLACK));

    always_ff @(posedge mem_slave)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            readdatavalid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            // One pulse per served read, aligned with the registered data
            readdatavalid <= (head_cmd == CMD_READ);
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            fifo_cmd[wr_ptr]  <= write ? CMD_WRITE : CMD_READ;
            fifo_addr[wr_ptr] <= address;
            fifo_data[wr_ptr] <= writedata;
            fifo_be[wr_ptr]   <= byteenable;
        end

        case (head_cmd)
            CMD_WRITE:
                // Only the enabled bytes change in the stored word
                for (int i = 0; i < BE_WIDTH; i++)
                begin
                    if (fifo_be[rd_ptr][i])
                        mem_array[head_addr][8*i +: 8] <= fifo_data[rd_ptr][8*i +: 8];
                end
            CMD_READ:
                readdata <= mem_array[head_addr];
            default:
                ;
        endcase
    end

    // The upstream slack budget must keep the queue from overflowing
    a_no_push_full: assert property (@(posedge mem_slave) disable iff (!rst_n)
        push |-> (count != (MEM_PTR_WIDTH+1)'(MEM_FIFO_DEPTH)));

endmodule

`default_nettype wire

// File: src/avmm_subsystem.sv
`default_nettype none

module avmm_subsystem import avmm_pkg::*;
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  logic                  refresh,
    input  logic [ADDR_WIDTH-1:0] a_address,
    input  logic                  a_read,
    input  logic                  a_write,
    input  logic [DATA_WIDTH-1:0] a_writedata,
    input  logic [BE_WIDTH-1:0]   a_byteenable,
    output logic                  a_waitrequest,
    output logic [DATA_WIDTH-1:0] a_readdata,
    output logic                  a_readdatavalid,
    input  logic [ADDR_WIDTH-1:0] b_address,
    input  logic                  b_read,
    input  logic                  b_write,
    input  logic [DATA_WIDTH-1:0] b_writedata,
    input  logic [BE_WIDTH-1:0]   b_byteenable,
    output logic                  b_waitrequest,
    output logic [DATA_WIDTH-1:0] b_readdata,
    output logic                  b_readdatavalid
);

    // Arbiter side of the register slice
    logic [ADDR_WIDTH-1:0] arb_address;
    logic                  arb_read;
    logic                  arb_write;
    logic [DATA_WIDTH-1:0] arb_writedata;
    logic [BE_WIDTH-1:0]   arb_byteenable;
    logic                  arb_waitrequest;
    logic [DATA_WIDTH-1:0] arb_readdata;
    logic                  arb_readdatavalid;

    // Memory side of the register slice
    logic [ADDR_WIDTH-1:0] mem_address;
    logic                  mem_read;
    logic                  mem_write;
    logic [DATA_WIDTH-1:0] mem_writedata;
    logic [BE_WIDTH-1:0]   mem_byteenable;
    logic                  mem_waitrequest;
    logic [DATA_WIDTH-1:0] mem_readdata;
    logic                  mem_readdatavalid;

    avmm_arbiter arb0
    (
        .mem_slave, .rst_n,
        .a_address, .a_read, .a_write, .a_writedata, .a_byteenable,
        .a_waitrequest, .a_readdata, .a_readdatavalid,
        .b_address, .b_read, .b_write, .b_writedata, .b_byteenable,
        .b_waitrequest, .b_readdata, .b_readdatavalid,
        .arb_address, .arb_read, .arb_write, .arb_writedata, .arb_byteenable,
        .arb_waitrequest, .arb_readdata, .arb_readdatavalid
    );

    // The memory slack is sized from these same stage counts
    avmm_reg_slice
    #(
        .N_STAGES    (N_REG_STAGES),
        .N_WR_STAGES (N_WAITREQUEST_STAGES)
    )
    slice0
    (
        .mem_slave        (mem_slave),
        .rst_n            (rst_n),
        .up_address       (arb_address),
        .up_read          (arb_read),
        .up_write         (arb_write),
        .up_writedata     (arb_writedata),
        .up_byteenable    (arb_byteenable),
        .up_waitrequest   (arb_waitrequest),
        .up_readdata      (arb_readdata),
        .up_readdatavalid (arb_readdatavalid),
        .dn_address       (mem_address),
        .dn_read          (mem_read),
        .dn_write         (mem_write),
        .dn_writedata     (mem_writedata),
        .dn_byteenable    (mem_byteenable),
        .dn_waitrequest   (mem_waitrequest),
        .dn_readdata      (mem_readdata),
        .dn_readdatavalid (mem_readdatavalid)
    );

    avmm_mem mem0
    (
        .mem_slave     (mem_slave),
        .rst_n         (rst_n),
        .refresh       (refresh),
        .address       (mem_address),
        .read          (mem_read),
        .write         (mem_write),
        .writedata     (mem_writedata),
        .byteenable    (mem_byteenable),
        .waitrequest   (mem_waitrequest),
        .readdata      (mem_readdata),
        .readdatavalid (mem_readdatavalid)
    );

endmodule

`default_nettype wire

// File: verification/avmm_checker.sv
`default_nettype none

module avmm_checker import avmm_pkg::*;
(
    input  logic                  mem_slave,
    input  logic                  rst_n,
    input  int                    test_id,
    input  logic [ADDR_WIDTH-1:0] a_address,
    input  logic                  a_read,
    input  logic                  a_write,
    input  logic [DATA_WIDTH-1:0] a_writedata,
    input  logic [BE_WIDTH-1:0]   a_byteenable,
    input  logic                  a_waitrequest,
    input  logic [DATA_WIDTH-1:0] a_readdata,
    input  logic                  a_readdatavalid,
    input  logic [ADDR_WIDTH-1:0] b_address,
    input  logic                  b_read,
    input  logic                  b_write,
    input  logic [DATA_WIDTH-1:0] b_writedata,
    input  logic [BE_WIDTH-1:0]   b_byteenable,
    input  logic                  b_waitrequest,
    input  logic [DATA_WIDTH-1:0] b_readdata,
    input  logic                  b_readdatavalid,
    output int                    outstanding,
    output int                    error_total,
    output logic                  report_done
);
    timeunit 1ns;
    timeprecision 100ps;

    // Reference copy of the memory, updated in acceptance order
    logic [DATA_WIDTH-1:0] model [1 << ADDR_WIDTH];
    // Expected read data per port, oldest first
    logic [DATA_WIDTH-1:0] exp_a [$];
    logic [DATA_WIDTH-1:0] exp_b [$];
    int                    cur_test = 1;
    int                    checks = 0;
    int                    errors = 0;
    int                    total_checks = 0;
    int                    total_errors = 0;
    int                    pending = 0;
    int                    rst_cyc = 0;
    logic                  done_flag = 1'b0;
    // After reset port b counts as the last winner
    logic                  last_port = 1'b1;

    assign outstanding = pending;
    assign error_total = total_errors;
    assign report_done = done_flag;

    task check(input logic ok, input string what);
        checks++;
        if (!ok)
        begin
            errors++;
            $display("%s (time %0t)", what, $time);
        end
    endtask

    task compare_read(input logic port, input logic [DATA_WIDTH-1:0] got);
        logic [DATA_WIDTH-1:0] want;
        checks++;
        if ((port ? exp_b.size() : exp_a.size()) == 0)
        begin
            errors++;
            $display("Read response on port %s with no read outstanding (time %0t)",
                     port ? "b" : "a", $time);
        end
        else
        begin
            if (port)
                want = exp_b.pop_front();
            else
                want = exp_a.pop_front();
            if (got !== want)
            begin
                errors++;
                $display("Fail at %0t: port %s read returned %h, expected %h",
                         $time, port ? "b" : "a", got, want);
            end
        end
    endtask

    // Records one accepted transfer and checks the round-robin rule for it
    task note_accept(input logic port, input logic wr, input logic [ADDR_WIDTH-1:0] addr,
                     input logic [DATA_WIDTH-1:0] data, input logic [BE_WIDTH-1:0] be,
                     input logic other_ready);
        checks++;
        if (port == last_port && other_ready)
        begin
            errors++;
            $display("Fail at %0t: port %s accepted twice in a row while port %s waited",
                     $time, port ? "b" : "a", port ? "a" : "b");
        end
        last_port = port;
        if (wr)
        begin
            for (int i = 0; i < BE_WIDTH; i++)
            begin
                if (be[i])
                    model[addr][8*i +: 8] = data[8*i +: 8];
            end
        end
        else if (port)
            exp_b.push_back(model[addr]);
        else
            exp_a.push_back(model[addr]);
    endtask

    // Closes the current test and, at the end of the run, reports lost reads
    task end_test();
        logic [DATA_WIDTH-1:0] lost;
        if (test_id == 0)
        begin
            while (exp_a.size() != 0)
            begin
                lost = exp_a.pop_front();
                checks++;
                errors++;
                $display("Read on port a never got its response (expected %h)", lost);
            end
            while (exp_b.size() != 0)
            begin
                lost = exp_b.pop_front();
                checks++;
                errors++;
                $display("Read on port b never got its response (expected %h)", lost);
            end
        end
        $display("Test %0d finished: %0d checks, %0d errors", cur_test, checks, errors);
        total_checks += checks;
        total_errors += errors;
        checks   = 0;
        errors   = 0;
        cur_test = test_id;
        if (test_id == 0)
        begin
            $display("Summary: %0d checks passed, %0d checks failed",
                     total_checks - total_errors, total_errors);
            done_flag = 1'b1;
        end
    endtask

    // Everything is sampled at the falling edge where inputs and outputs are settled
    always @(negedge mem_slave)
    begin
        logic a_ready;
        logic b_ready;
        int   pend;
        if (test_id != cur_test)
            end_test();
        if (!rst_n)
        begin
            check(a_readdatavalid === 1'b0 && b_readdatavalid === 1'b0,
                  "readdatavalid was high during reset");
            rst_cyc   = 0;
            last_port = 1'b1;
            exp_a.delete();
            exp_b.delete();
        end
        else
        begin
            // Waitrequest starts high and must drop once the slice pipeline refills
            if (rst_cyc == 0)
                check(a_waitrequest && b_waitrequest,
                      "waitrequest was low in the first cycle after reset");
            if (rst_cyc == N_WAITREQUEST_STAGES + 1)
                check(!a_waitrequest && !b_waitrequest,
                      "waitrequest was still high well after reset");
            if (rst_cyc <= N_WAITREQUEST_STAGES + 1)
                rst_cyc++;
            // A waiting read only competes while the return order queue has room
            pend    = exp_a.size() + exp_b.size();
            a_ready = a_write || (a_read && pend < RD_ORDER_DEPTH);
            b_ready = b_write || (b_read && pend < RD_ORDER_DEPTH);
            if (a_readdatavalid)
                compare_read(1'b0, a_readdata);
            if (b_readdatavalid)
                compare_read(1'b1, b_readdata);
            if ((a_read || a_write) && !a_waitrequest)
                note_accept(1'b0, a_write, a_address, a_writedata, a_byteenable, b_ready);
            if ((b_read || b_write) && !b_waitrequest)
                note_accept(1'b1, b_write, b_address, b_writedata, b_byteenable, a_ready);
        end
        pending = exp_a.size() + exp_b.size();
    end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`default_nettype none

module tb_top import avmm_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    // One table row per transfer with port 0 for a and port 1 for b
    typedef struct packed
    {
        logic [3:0]            test;
        logic                  port;
        logic                  wr;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [BE_WIDTH-1:0]   be;
    } stim_t;

    localparam int N_STIM = 34;
    // Generous budget per transfer plus room for reset and draining
    localparam int TIMEOUT_CYCLES = 40 * N_STIM + 100;

    logic                  mem_slave;
    logic                  rst_n;
    logic                  refresh;
    logic [ADDR_WIDTH-1:0] a_address;
    logic                  a_read;
    logic                  a_write;
    logic [DATA_WIDTH-1:0] a_writedata;
    logic [BE_WIDTH-1:0]   a_byteenable;
    logic                  a_waitrequest;
    logic [DATA_WIDTH-1:0] a_readdata;
    logic                  a_readdatavalid;
    logic [ADDR_WIDTH-1:0] b_address;
    logic                  b_read;
    logic                  b_write;
    logic [DATA_WIDTH-1:0] b_writedata;
    logic [BE_WIDTH-1:0]   b_byteenable;
    logic                  b_waitrequest;
    logic [DATA_WIDTH-1:0] b_readdata;
    logic                  b_readdatavalid;
    int                    test_id;
    int                    outstanding;
    int                    error_total;
    logic                  report_done;
    logic                  rand_refresh;
    integer                seed = 16128;
    int                    cycles = 0;

    // Port a stays in the lower half of memory and port b in the upper half
    stim_t stim [N_STIM] = '{
        // Test 2 writes full words, reads back, then merges a partial write into word 10
        '{4'd2, 1'b0, 1'b1, 8'd10,  32'h1111_2222, 4'hf},
        '{4'd2, 1'b0, 1'b1, 8'd11,  32'h3333_4444, 4'hf},
        '{4'd2, 1'b0, 1'b0, 8'd10,  32'h0,         4'hf},
        '{4'd2, 1'b0, 1'b1, 8'd10,  32'haaaa_bbbb, 4'h3},
        '{4'd2, 1'b0, 1'b0, 8'd10,  32'h0,         4'hf},
        '{4'd2, 1'b0, 1'b0, 8'd11,  32'h0,         4'hf},
        // Test 3 interleaves both ports
        '{4'd3, 1'b0, 1'b1, 8'd20,  32'h5555_6666, 4'hf},
        '{4'd3, 1'b1, 1'b1, 8'd130, 32'h7777_8888, 4'hf},
        '{4'd3, 1'b0, 1'b0, 8'd20,  32'h0,         4'hf},
        '{4'd3, 1'b1, 1'b0, 8'd130, 32'h0,         4'hf},
        '{4'd3, 1'b0, 1'b1, 8'd21,  32'h9999_0000, 4'hf},
        '{4'd3, 1'b1, 1'b1, 8'd131, 32'habcd_ef01, 4'hf},
        '{4'd3, 1'b1, 1'b0, 8'd131, 32'h0,         4'hf},
        '{4'd3, 1'b0, 1'b0, 8'd21,  32'h0,         4'hf},
        // Test 4 repeats the same kind of traffic while refresh toggles
        '{4'd4, 1'b0, 1'b1, 8'd30,  32'h0102_0304, 4'hf},
        '{4'd4, 1'b0, 1'b1, 8'd31,  32'h0506_0708, 4'hf},
        '{4'd4, 1'b0, 1'b0, 8'd30,  32'h0,         4'hf},
        '{4'd4, 1'b0, 1'b0, 8'd31,  32'h0,         4'hf},
        '{4'd4, 1'b0, 1'b0, 8'd10,  32'h0,         4'hf},
        '{4'd4, 1'b1, 1'b1, 8'd140, 32'h1357_9bdf, 4'hf},
        '{4'd4, 1'b1, 1'b0, 8'd140, 32'h0,         4'hf},
        '{4'd4, 1'b1, 1'b1, 8'd140, 32'hff00_0000, 4'h8},
        '{4'd4, 1'b1, 1'b0, 8'd140, 32'h0,         4'hf},
        '{4'd4, 1'b1, 1'b0, 8'd131, 32'h0,         4'hf},
        // Test 5 keeps both ports requesting so grants must alternate
        '{4'd5, 1'b0, 1'b1, 8'd40,  32'h4040_0000, 4'hf},
        '{4'd5, 1'b0, 1'b1, 8'd41,  32'h4141_0101, 4'hf},
        '{4'd5, 1'b0, 1'b1, 8'd42,  32'h4242_0202, 4'hf},
        '{4'd5, 1'b0, 1'b1, 8'd43,  32'h4343_0303, 4'hf},
        '{4'd5, 1'b0, 1'b0, 8'd41,  32'h0,         4'hf},
        '{4'd5, 1'b1, 1'b1, 8'd150, 32'h5050_0000, 4'hf},
        '{4'd5, 1'b1, 1'b1, 8'd151, 32'h5151_0101, 4'hf},
        '{4'd5, 1'b1, 1'b1, 8'd152, 32'h5252_0202, 4'hf},
        '{4'd5, 1'b1, 1'b1, 8'd153, 32'h5353_0303, 4'hf},
        '{4'd5, 1'b1, 1'b0, 8'd152, 32'h0,         4'hf}
    };

    avmm_subsystem dut0 (.*);

    avmm_checker chk0 (.*);

    initial
    begin
        mem_slave = 1'b0;
        forever #5 mem_slave = ~mem_slave;
    end

    // Puts one table row on a port, or clears the port when active is low
    task automatic set_request(input logic port, input stim_t s, input logic active);
        if (port == 1'b0)
        begin
            a_address    = s.addr;
            a_read       = active && !s.wr;
            a_write      = active && s.wr;
            a_writedata  = s.data;
            a_byteenable = s.be;
        end
        else
        begin
            b_address    = s.addr;
            b_read       = active && !s.wr;
            b_write      = active && s.wr;
            b_writedata  = s.data;
            b_byteenable = s.be;
        end
    endtask

    // Applies every row of one test that belongs to one port, each held until taken
    task automatic run_port(input logic port, input int test);
        logic accepted;
        for (int i = 0; i < N_STIM; i++)
        begin
            if (int'(stim[i].test) == test && stim[i].port == port)
            begin
                set_request(port, stim[i], 1'b1);
                accepted = 1'b0;
                while (!accepted)
                begin
                    // Waitrequest is settled at the falling edge
                    @(negedge mem_slave);
                    accepted = port ? !b_waitrequest : !a_waitrequest;
                    @(posedge mem_slave);
                    #1;
                end
            end
        end
        set_request(port, '0, 1'b0);
    endtask

    // Refresh only toggles while the back-pressure test runs
    initial
    begin
        logic enable;
        forever
        begin
            @(posedge mem_slave);
            enable = rand_refresh;
            #1;
            if (enable)
                refresh = 1'($random(seed));
            else
                refresh = 1'b0;
        end
    end

    always @(posedge mem_slave)
    begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        int drain;
        rst_n        = 1'b0;
        refresh      = 1'b0;
        rand_refresh = 1'b0;
        test_id      = 1;
        set_request(1'b0, '0, 1'b0);
        set_request(1'b1, '0, 1'b0);
        repeat (5) @(posedge mem_slave);
        #1;
        rst_n = 1'b1;
        // Test 1 only watches the ports come out of reset
        repeat (4) @(posedge mem_slave);
        #1;
        for (int t = 2; t <= 5; t++)
        begin
            test_id      = t;
            rand_refresh = (t == 4);
            fork
                run_port(1'b0, t);
                run_port(1'b1, t);
            join
            rand_refresh = 1'b0;
            // Let outstanding reads come back before the next test starts
            drain = 0;
            while (outstanding != 0 && drain < 200)
            begin
                @(posedge mem_slave);
                drain++;
            end
            @(posedge mem_slave);
            #1;
        end
        test_id = 0;
        wait (report_done);
        // The checker totals settle one step after its done flag
        #1;
        if (error_total == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
src/avmm_pkg.sv
src/avmm_arbiter.sv
src/avmm_reg_slice.sv
src/avmm_mem.sv
src/avmm_subsystem.sv
verification/avmm_checker.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module tb_top --Mdir "$BUILD_DIR" -o tb_top_sim \
    -f filelist.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "test failed" "$SIM_LOG"; then
    exit 1
fi
exit 0
